// ==== vid_top.f ====
+incdir+.
vid_pkg.sv
vid_regbus_decode.sv
vid_main_ram.sv
vid_line_fetch.sv
vid_line_buffer.sv
vid_video_timing.sv
vid_pixel_out.sv
vid_top.sv
tb_vid_checker.sv
tb_vid_top.sv

// ==== Bender.yml ====
package:
  name: vid_top

export_include_dirs:
  - .

sources:
  - files:
      - vid_pkg.sv
      - vid_regbus_decode.sv
      - vid_main_ram.sv
      - vid_line_fetch.sv
      - vid_line_buffer.sv
      - vid_video_timing.sv
      - vid_pixel_out.sv
      - vid_top.sv
  - target: test
    files:
      - tb_vid_checker.sv
      - tb_vid_top.sv

// ==== tb_vid_top.sv ====
`include "vid_consts.svh"

module tb_vid_top import vid_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 2;
    localparam int RAM_BYTES    = `VID_RAM_WORDS * 4;
    localparam int PAL_BYTES    = 512;
    localparam int FRAME_PIX    = `VID_V_ACTIVE * `VID_H_ACTIVE;
    localparam int FRAME_CYCLES = `VID_H_TOTAL * `VID_V_TOTAL;
    localparam int N_RAND_WR    = 64;
    localparam int N_PAL_RD     = 64;
    localparam int N_FRAME_RD   = 8;
    // Every host access takes two clock cycles
    localparam int HOST_ACCESSES = 2 * (FRAME_PIX + N_RAND_WR) + PAL_BYTES + N_PAL_RD + 3;
    localparam int WATCHDOG_NS   = (RESET_CYCLES + 2 * HOST_ACCESSES + 3 * FRAME_CYCLES +
                                    FRAME_CYCLES / 2) * CLK_PERIOD;

    localparam host_addr_t PAL_BASE  = `VID_PAL_BASE;
    localparam host_addr_t CTRL_ADDR = `VID_CTRL_ADDR;
    localparam host_addr_t STAT_ADDR = `VID_STAT_ADDR;

    logic                    clk;
    logic                    reset;
    host_req_t               host_req;
    byte_t                   exp_rd;
    logic [1:0]              phase;
    logic                    display_on;
    logic [FRAME_PIX*12-1:0] exp_frame;
    byte_t                   rddata;
    logic                    rdvalid;
    logic                    irq;
    rgb12_t                  rgb;
    logic                    de;
    logic                    hsync;
    logic                    vsync;
    int                      error_cnt;
    int                      check_cnt;
    int                      frames_done;
    int unsigned             seed_val;

    // Shadow copies of the host-visible state
    byte_t       shadow_ram [RAM_BYTES];
    logic [15:0] shadow_pal [256];
    logic [1:0]  shadow_ctrl;
    logic        shadow_stat;
    host_addr_t  written_q [$];

    vid_top u_dut (
        .clk        (clk),
        .reset      (reset),
        .host_req_i (host_req),
        .rddata_o   (rddata),
        .rdvalid_o  (rdvalid),
        .irq_o      (irq),
        .rgb_o      (rgb),
        .de_o       (de),
        .hsync_o    (hsync),
        .vsync_o    (vsync)
    );

    tb_vid_checker u_checker (
        .clk           (clk),
        .reset         (reset),
        .host_req_i    (host_req),
        .exp_rd_i      (exp_rd),
        .phase_i       (phase),
        .display_on_i  (display_on),
        .exp_frame_i   (exp_frame),
        .rddata_i      (rddata),
        .rdvalid_i     (rdvalid),
        .irq_i         (irq),
        .rgb_i         (rgb),
        .de_i          (de),
        .hsync_i       (hsync),
        .vsync_i       (vsync),
        .error_cnt_o   (error_cnt),
        .check_cnt_o   (check_cnt),
        .frames_done_o (frames_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////
    function automatic byte_t expected_read(input host_addr_t addr);
        if (addr < RAM_BYTES) begin
            return shadow_ram[addr];
        end
        if (addr >= PAL_BASE && addr < PAL_BASE + PAL_BYTES) begin
            // Low byte of an entry sits at the even address
            return addr[0] ? shadow_pal[addr[8:1]][15:8] : shadow_pal[addr[8:1]][7:0];
        end
        if (addr == CTRL_ADDR) begin
            return {6'b0, shadow_ctrl};
        end
        if (addr == STAT_ADDR) begin
            return {7'b0, shadow_stat};
        end
        return 8'h00;
    endfunction

    function automatic rgb12_t expected_rgb(input int y, input int x);
        return shadow_pal[shadow_ram[y * `VID_H_ACTIVE + x]][11:0];
    endfunction

    function automatic void update_shadow(input host_addr_t addr, input byte_t data);
        if (addr < RAM_BYTES) begin
            shadow_ram[addr] = data;
        end else if (addr >= PAL_BASE && addr < PAL_BASE + PAL_BYTES) begin
            if (addr[0]) begin
                shadow_pal[addr[8:1]][15:8] = data;
            end else begin
                shadow_pal[addr[8:1]][7:0] = data;
            end
        end else if (addr == CTRL_ADDR) begin
            shadow_ctrl = data[1:0];
        end else if (addr == STAT_ADDR && data[0]) begin
            shadow_stat = 1'b0;
        end
    endfunction

    //////////////////////////////////////////////////
    // Host bus access
    //////////////////////////////////////////////////
    task automatic host_write(input host_addr_t addr, input byte_t data);
        @(negedge clk);
        host_req.strobe = 1'b1;
        host_req.write  = 1'b1;
        host_req.addr   = addr;
        host_req.wrdata = data;
        update_shadow(addr, data);
        @(negedge clk);
        host_req.strobe = 1'b0;
    endtask

    task automatic host_read(input host_addr_t addr);
        @(negedge clk);
        host_req.strobe = 1'b1;
        host_req.write  = 1'b0;
        host_req.addr   = addr;
        host_req.wrdata = 8'h00;
        exp_rd          = expected_read(addr);
        @(negedge clk);
        host_req.strobe = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Test phases
    //////////////////////////////////////////////////
    task automatic write_ram_bytes();
        host_addr_t addr;
        // Whole bitmap first so every displayed byte is known
        for (int a = 0; a < FRAME_PIX; a++) begin
            addr = host_addr_t'(a);
            host_write(addr, byte_t'($urandom));
            written_q.push_back(addr);
        end
        for (int i = 0; i < N_RAND_WR; i++) begin
            addr = host_addr_t'($urandom % RAM_BYTES);
            host_write(addr, byte_t'($urandom));
            written_q.push_back(addr);
        end
    endtask

    task automatic read_back_ram();
        foreach (written_q[i]) begin
            host_read(written_q[i]);
        end
    endtask

    task automatic write_palette();
        for (int idx = 0; idx < 256; idx++) begin
            host_write(PAL_BASE + host_addr_t'(2 * idx), byte_t'($urandom));
            host_write(PAL_BASE + host_addr_t'(2 * idx + 1), byte_t'($urandom));
        end
    endtask

    task automatic read_back_palette();
        for (int i = 0; i < N_PAL_RD; i++) begin
            host_read(PAL_BASE + host_addr_t'($urandom % PAL_BYTES));
        end
    endtask

    task automatic build_frame_image();
        for (int y = 0; y < `VID_V_ACTIVE; y++) begin
            for (int x = 0; x < `VID_H_ACTIVE; x++) begin
                exp_frame[(y * `VID_H_ACTIVE + x) * 12 +: 12] = expected_rgb(y, x);
            end
        end
    endtask

    task automatic pick_random_read();
        if ($urandom % 2) begin
            host_read(written_q[$urandom % written_q.size()]);
        end else begin
            host_read(PAL_BASE + host_addr_t'($urandom % PAL_BYTES));
        end
    endtask

    task automatic scan_frames();
        int gap;
        host_write(STAT_ADDR, 8'h01);
        host_write(CTRL_ADDR, 8'h03);
        display_on = 1'b1;
        host_read(CTRL_ADDR);
        while (frames_done < 2) begin
            @(negedge clk);
            if (irq) begin
                host_write(STAT_ADDR, 8'h01);
                host_read(STAT_ADDR);
                // Reads spill into the next active lines
                for (int i = 0; i < N_FRAME_RD; i++) begin
                    gap = 2 + $urandom % 8;
                    repeat (gap) @(negedge clk);
                    pick_random_read();
                end
            end
        end
    endtask

    initial begin
        seed_val    = $urandom(32'h561e);
        host_req    = '0;
        exp_rd      = 8'h00;
        phase       = 2'd0;
        display_on  = 1'b0;
        exp_frame   = '0;
        shadow_ctrl = 2'b00;
        shadow_stat = 1'b0;
        reset       = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        phase = 2'd1;
        write_ram_bytes();
        read_back_ram();
        phase = 2'd2;
        write_palette();
        read_back_palette();
        build_frame_image();
        phase = 2'd3;
        scan_frames();
        repeat (4) @(negedge clk);

        $display("Checks run: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not complete within %0d ns", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== tb_vid_checker.sv ====
`include "vid_consts.svh"

module tb_vid_checker import vid_pkg::*; #(
    parameter int FRAME_PIX = `VID_V_ACTIVE * `VID_H_ACTIVE
) (
    input  logic                    clk,
    input  logic                    reset,
    input  host_req_t               host_req_i,
    input  byte_t                   exp_rd_i,
    input  logic [1:0]              phase_i,
    input  logic                    display_on_i,
    input  logic [FRAME_PIX*12-1:0] exp_frame_i,
    input  byte_t                   rddata_i,
    input  logic                    rdvalid_i,
    input  logic                    irq_i,
    input  rgb12_t                  rgb_i,
    input  logic                    de_i,
    input  logic                    hsync_i,
    input  logic                    vsync_i,
    output int                      error_cnt_o,
    output int                      check_cnt_o,
    output int                      frames_done_o
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam host_addr_t STAT_ADDR = `VID_STAT_ADDR;

    int         errors;
    int         checks;
    int         frames_done;
    int         de_cnt;
    int         hs_low;
    int         irq_rises;
    logic       reset_checked;
    logic       rd_pending;
    byte_t      rd_exp;
    logic [1:0] rd_phase;
    logic       clear_pending;
    logic       vsync_d;
    logic       irq_d;
    logic       frame_seen;
    logic       pix_armed;

    assign error_cnt_o   = errors;
    assign check_cnt_o   = checks;
    assign frames_done_o = frames_done;

    function automatic string phase_name(input logic [1:0] ph);
        case (ph)
            2'd1:    return "ram readback";
            2'd2:    return "palette readback";
            2'd3:    return "display readback";
            default: return "readback";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic report_fault(input string what);
        checks = checks + 1;
        errors = errors + 1;
        $display("Check failed: %s", what);
    endtask

    //////////////////////////////////////////////////
    // Sampled on the rising edge, before the DUT updates
    //////////////////////////////////////////////////
    always @(posedge clk) begin
        if (reset) begin
            reset_checked = 1'b0;
            rd_pending    = 1'b0;
            clear_pending = 1'b0;
            vsync_d       = 1'b1;
            irq_d         = 1'b0;
            frame_seen    = 1'b0;
            pix_armed     = 1'b0;
            de_cnt        = 0;
            hs_low        = 0;
            irq_rises     = 0;
        end else begin
            if (!reset_checked) begin
                check_value("reset rgb_o", 0, rgb_i);
                check_value("reset de_o", 0, de_i);
                check_value("reset hsync_o", 1, hsync_i);
                check_value("reset vsync_o", 1, vsync_i);
                check_value("reset irq_o", 0, irq_i);
                reset_checked = 1'b1;
            end

            // Read data one cycle after each read strobe
            if (rdvalid_i !== rd_pending) begin
                report_fault(rd_pending ? "rdvalid_o missing one cycle after a host read" :
                                          "rdvalid_o high without a host read");
            end else if (rd_pending) begin
                check_value(phase_name(rd_phase), rd_exp, rddata_i);
            end
            rd_pending = host_req_i.strobe && !host_req_i.write;
            rd_exp     = exp_rd_i;
            rd_phase   = phase_i;

            if (clear_pending) begin
                check_value("irq clear", 0, irq_i);
            end
            clear_pending = host_req_i.strobe && host_req_i.write &&
                            host_req_i.addr == STAT_ADDR && host_req_i.wrdata[0];

            // Blank outside the active area and while the display is off
            if (!de_i || !display_on_i) begin
                check_value("blank rgb_o", 0, rgb_i);
            end

            // Both enables stay off until the scan phase
            if (!display_on_i) begin
                check_value("irq disabled", 0, irq_i);
            end

            // Sync pulse width
            if (!hsync_i) begin
                hs_low = hs_low + 1;
            end else if (hs_low != 0) begin
                check_value("hsync width", `VID_H_SYNC_LEN, hs_low);
                hs_low = 0;
            end

            if (irq_i && !irq_d) begin
                irq_rises = irq_rises + 1;
            end

            // Pixels in raster order
            if (de_i) begin
                if (pix_armed && de_cnt < FRAME_PIX) begin
                    check_value($sformatf("pixel y%0d x%0d", de_cnt / `VID_H_ACTIVE,
                                          de_cnt % `VID_H_ACTIVE),
                                exp_frame_i[de_cnt*12 +: 12], rgb_i);
                end
                de_cnt = de_cnt + 1;
            end

            // Frame boundary on falling vsync
            if (!vsync_i && vsync_d) begin
                if (frame_seen) begin
                    check_value("de pixels per frame", FRAME_PIX, de_cnt);
                end
                if (pix_armed) begin
                    check_value("irq per frame", 1, irq_rises);
                    frames_done = frames_done + 1;
                end
                frame_seen = 1'b1;
                pix_armed  = display_on_i;
                de_cnt     = 0;
                irq_rises  = 0;
            end
            vsync_d = vsync_i;
            irq_d   = irq_i;
        end
    end

endmodule

// ==== vid_top.sv ====
module vid_top import vid_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  host_req_t host_req_i,
    output byte_t     rddata_o,
    output logic      rdvalid_o,
    output logic      irq_o,
    output rgb12_t    rgb_o,
    output logic      de_o,
    output logic      hsync_o,
    output logic      vsync_o
);

    video_evt_t evt;
    mem_req_t   fetch_req;
    logic       fetch_ack;
    mem_req_t   mem_req;
    mem_word_t  mem_rddata;
    logic       pal_we;
    byte_t      pal_rdbyte;
    logic       display_en;
    logic       lb_we;
    pix_idx_t   lb_wridx;
    mem_word_t  lb_wrdata;
    byte_t      lb_rdpix;
    logic       tim_hsync;
    logic       tim_vsync;

    //////////////////////////////////////////////////
    // Host side and memory
    //////////////////////////////////////////////////
    vid_regbus_decode u_decode (
        .clk          (clk),
        .reset        (reset),
        .host_req_i   (host_req_i),
        .rddata_o     (rddata_o),
        .rdvalid_o    (rdvalid_o),
        .irq_o        (irq_o),
        .display_en_o (display_en),
        .evt_i        (evt),
        .fetch_req_i  (fetch_req),
        .fetch_ack_o  (fetch_ack),
        .mem_req_o    (mem_req),
        .mem_rddata_i (mem_rddata),
        .pal_we_o     (pal_we),
        .pal_rdbyte_i (pal_rdbyte)
    );

    vid_main_ram u_main_ram (
        .clk       (clk),
        .mem_req_i (mem_req),
        .rddata_o  (mem_rddata)
    );

    //////////////////////////////////////////////////
    // Scan-out path
    //////////////////////////////////////////////////
    vid_video_timing u_timing (
        .clk     (clk),
        .reset   (reset),
        .evt_o   (evt),
        .hsync_o (tim_hsync),
        .vsync_o (tim_vsync)
    );

    vid_line_fetch u_fetch (
        .clk          (clk),
        .reset        (reset),
        .evt_i        (evt),
        .fetch_req_o  (fetch_req),
        .fetch_ack_i  (fetch_ack),
        .mem_rddata_i (mem_rddata),
        .lb_we_o      (lb_we),
        .lb_wridx_o   (lb_wridx),
        .lb_wrdata_o  (lb_wrdata)
    );

    vid_line_buffer u_line_buf (
        .clk      (clk),
        .reset    (reset),
        .evt_i    (evt),
        .we_i     (lb_we),
        .wridx_i  (lb_wridx),
        .wrdata_i (lb_wrdata),
        .rdidx_i  (evt.pix_idx),
        .rdpix_o  (lb_rdpix)
    );

    vid_pixel_out u_pixel_out (
        .clk          (clk),
        .reset        (reset),
        .host_req_i   (host_req_i),
        .pal_we_i     (pal_we),
        .pal_rdbyte_o (pal_rdbyte),
        .pix_i        (lb_rdpix),
        .active_i     (evt.active),
        .hsync_i      (tim_hsync),
        .vsync_i      (tim_vsync),
        .display_en_i (display_en),
        .rgb_o        (rgb_o),
        .de_o         (de_o),
        .hsync_o      (hsync_o),
        .vsync_o      (vsync_o)
    );

endmodule

// ==== vid_pixel_out.sv ====
`include "vid_consts.svh"

module vid_pixel_out import vid_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  host_req_t host_req_i,
    input  logic      pal_we_i,
    output byte_t     pal_rdbyte_o,
    input  byte_t     pix_i,
    input  logic      active_i,
    input  logic      hsync_i,
    input  logic      vsync_i,
    input  logic      display_en_i,
    output rgb12_t    rgb_o,
    output logic      de_o,
    output logic      hsync_o,
    output logic      vsync_o
);

    typedef struct packed {
        logic active;
        logic hsync;
        logic vsync;
    } vctl_t;

    logic [15:0] pal_q [256];
    logic [15:0] pal_rd_r;
    rgb12_t      pal_rgb_r;
    logic        rd_hi_r;
    byte_t       pal_idx;
    vctl_t       ctl_s1_r;
    vctl_t       ctl_s2_r;

    assign pal_idx = host_req_i.addr[`VID_PAL_BYTES_AW-1:1];

    //////////////////////////////////////////////////
    // Palette, host port and scan-out port
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (pal_we_i) begin
            if (host_req_i.addr[0]) begin
                pal_q[pal_idx][15:8] <= host_req_i.wrdata;
            end else begin
                pal_q[pal_idx][7:0] <= host_req_i.wrdata;
            end
        end
        pal_rd_r  <= pal_q[pal_idx];
        rd_hi_r   <= host_req_i.addr[0];
        pal_rgb_r <= pal_q[pix_i][11:0];
    end

    assign pal_rdbyte_o = rd_hi_r ? pal_rd_r[15:8] : pal_rd_r[7:0];

    //////////////////////////////////////////////////
    // Control delay and output register
    //////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctl_s1_r <= '{active: 1'b0, hsync: 1'b1, vsync: 1'b1};
            ctl_s2_r <= '{active: 1'b0, hsync: 1'b1, vsync: 1'b1};
            rgb_o    <= '0;
            de_o     <= 1'b0;
            hsync_o  <= 1'b1;
            vsync_o  <= 1'b1;
        end else begin
            ctl_s1_r <= '{active: active_i, hsync: hsync_i, vsync: vsync_i};
            ctl_s2_r <= ctl_s1_r;
            rgb_o    <= (ctl_s2_r.active && display_en_i) ? pal_rgb_r : '0;
            de_o     <= ctl_s2_r.active;
            hsync_o  <= ctl_s2_r.hsync;
            vsync_o  <= ctl_s2_r.vsync;
        end
    end

endmodule

// ==== vid_video_timing.sv ====
`include "vid_consts.svh"

module vid_video_timing import vid_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    output video_evt_t evt_o,
    output logic       hsync_o,
    output logic       vsync_o
);

    pix_idx_t  h_cnt_r;
    line_idx_t v_cnt_r;
    logic      h_last;
    logic      v_last;
    logic      h_active;
    logic      v_active;

    assign h_last   = h_cnt_r == pix_idx_t'(`VID_H_TOTAL - 1);
    assign v_last   = v_cnt_r == line_idx_t'(`VID_V_TOTAL - 1);
    assign h_active = h_cnt_r < pix_idx_t'(`VID_H_ACTIVE);
    assign v_active = v_cnt_r < line_idx_t'(`VID_V_ACTIVE);

    //////////////////////////////////////////////////
    // Counters
    //////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            h_cnt_r <= '0;
            v_cnt_r <= '0;
        end else if (h_last) begin
            h_cnt_r <= '0;
            v_cnt_r <= v_last ? '0 : v_cnt_r + 1'b1;
        end else begin
            h_cnt_r <= h_cnt_r + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Events and syncs
    //////////////////////////////////////////////////
    always_comb begin
        evt_o.start_of_line   = h_cnt_r == '0;
        evt_o.start_of_screen = h_cnt_r == '0 && v_cnt_r == '0;
        // First cycle after the last active pixel
        evt_o.end_of_screen   = h_cnt_r == pix_idx_t'(`VID_H_ACTIVE) &&
                                v_cnt_r == line_idx_t'(`VID_V_ACTIVE - 1);
        // Line 0 is fetched during the last line
        evt_o.next_line       = v_last ? '0 : v_cnt_r + 1'b1;
        evt_o.active          = h_active && v_active;
        evt_o.pix_idx         = h_cnt_r;
    end

    assign hsync_o = !(h_cnt_r >= pix_idx_t'(`VID_H_SYNC_START) &&
                       h_cnt_r <  pix_idx_t'(`VID_H_SYNC_START + `VID_H_SYNC_LEN));
    assign vsync_o = !(v_cnt_r >= line_idx_t'(`VID_V_SYNC_START) &&
                       v_cnt_r <  line_idx_t'(`VID_V_SYNC_START + `VID_V_SYNC_LEN));

endmodule

// ==== vid_line_buffer.sv ====
`include "vid_consts.svh"

module vid_line_buffer import vid_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  video_evt_t evt_i,
    input  logic       we_i,
    input  pix_idx_t   wridx_i,
    input  mem_word_t  wrdata_i,
    input  pix_idx_t   rdidx_i,
    output byte_t      rdpix_o
);

    localparam int WI_W = $clog2(`VID_WORDS_PER_LINE);

    mem_word_t   half_mem [2*`VID_WORDS_PER_LINE];
    logic        half_r;
    logic        rd_half;
    logic [WI_W:0] wr_addr;
    logic [WI_W:0] rd_addr;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            half_r <= 1'b0;
        end else if (evt_i.start_of_line) begin
            half_r <= !half_r;
        end
    end

    // Read side already sees the swap in the start_of_line cycle
    assign rd_half = !(half_r ^ evt_i.start_of_line);
    assign wr_addr = {half_r, wridx_i[WI_W+1:2]};
    assign rd_addr = {rd_half, rdidx_i[WI_W+1:2]};

    always_ff @(posedge clk) begin
        if (we_i) begin
            half_mem[wr_addr] <= wrdata_i;
        end
        rdpix_o <= half_mem[rd_addr][rdidx_i[1:0]*8 +: 8];
    end

endmodule

// ==== vid_line_fetch.sv ====
`include "vid_consts.svh"

module vid_line_fetch import vid_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  video_evt_t evt_i,
    output mem_req_t   fetch_req_o,
    input  logic       fetch_ack_i,
    input  mem_word_t  mem_rddata_i,
    output logic       lb_we_o,
    output pix_idx_t   lb_wridx_o,
    output mem_word_t  lb_wrdata_o
);

    localparam int CNT_W = $clog2(`VID_WORDS_PER_LINE);

    fetch_state_t     state_r;
    logic [CNT_W-1:0] word_cnt_r;
    line_idx_t        line_r;
    logic             start;
    logic             last_word;

    assign start     = evt_i.start_of_line && (state_r == IDLE || state_r == DONE);
    assign last_word = word_cnt_r == CNT_W'(`VID_WORDS_PER_LINE - 1);

    //////////////////////////////////////////////////
    // FSM and word counter
    //////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_r    <= IDLE;
            word_cnt_r <= '0;
        end else begin
            case (state_r)
                IDLE, DONE: begin
                    if (start) begin
                        state_r    <= REQ;
                        word_cnt_r <= '0;
                    end else begin
                        state_r <= IDLE;
                    end
                end
                // Address goes out, then held in WAIT until acked
                REQ: state_r <= WAIT;
                WAIT: begin
                    if (fetch_ack_i) begin
                        word_cnt_r <= word_cnt_r + 1'b1;
                        state_r    <= last_word ? DONE : REQ;
                    end
                end
                default: state_r <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            line_r <= evt_i.next_line;
        end
    end

    // Strobe drops in the ack cycle to avoid a second grant
    always_comb begin
        fetch_req_o.strobe  = (state_r == REQ) || (state_r == WAIT && !fetch_ack_i);
        fetch_req_o.write   = 1'b0;
        fetch_req_o.addr    = ram_addr_t'(line_r) * ram_addr_t'(`VID_WORDS_PER_LINE) +
                              ram_addr_t'(word_cnt_r);
        fetch_req_o.bytesel = 4'b1111;
        fetch_req_o.wrdata  = '0;
    end

    assign lb_we_o     = (state_r == WAIT) && fetch_ack_i;
    assign lb_wridx_o  = pix_idx_t'({word_cnt_r, 2'b00});
    assign lb_wrdata_o = mem_rddata_i;

    a_req_hold: assert property (@(posedge clk) disable iff (reset)
        fetch_req_o.strobe |=> fetch_ack_i ||
            (fetch_req_o.strobe && $stable(fetch_req_o.addr)));

endmodule

// ==== vid_main_ram.sv ====
`include "vid_consts.svh"

module vid_main_ram import vid_pkg::*; (
    input  logic      clk,
    input  mem_req_t  mem_req_i,
    output mem_word_t rddata_o
);

    mem_word_t mem_q [`VID_RAM_WORDS];

    //////////////////////////////////////////////////
    // Byte-lane write, registered read
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (mem_req_i.strobe) begin
            if (mem_req_i.write) begin
                for (int i = 0; i < 4; i++) begin
                    if (mem_req_i.bytesel[i]) begin
                        mem_q[mem_req_i.addr][i*8 +: 8] <= mem_req_i.wrdata[i*8 +: 8];
                    end
                end
            end
            // Old word on read-during-write
            rddata_o <= mem_q[mem_req_i.addr];
        end
    end

endmodule

// ==== vid_regbus_decode.sv ====
`include "vid_consts.svh"

module vid_regbus_decode import vid_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  host_req_t  host_req_i,
    output byte_t      rddata_o,
    output logic       rdvalid_o,
    output logic       irq_o,
    output logic       display_en_o,
    input  video_evt_t evt_i,
    input  mem_req_t   fetch_req_i,
    output logic       fetch_ack_o,
    output mem_req_t   mem_req_o,
    input  mem_word_t  mem_rddata_i,
    output logic       pal_we_o,
    input  byte_t      pal_rdbyte_i
);

    localparam host_addr_t PAL_BASE  = `VID_PAL_BASE;
    localparam host_addr_t CTRL_ADDR = `VID_CTRL_ADDR;
    localparam host_addr_t STAT_ADDR = `VID_STAT_ADDR;

    logic       ram_sel;
    logic       pal_sel;
    logic       ctrl_sel;
    logic       stat_sel;
    logic       host_ram;
    logic       host_wr;
    logic [1:0] ctrl_r;
    logic       eos_flag_r;
    logic       rd_ram_r;
    logic       rd_pal_r;
    logic [1:0] lane_r;
    byte_t      reg_rddata_r;

    //////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////
    // RAM occupies the lower half, aliased above its size
    assign ram_sel  = !host_req_i.addr[`VID_HOST_AW-1];
    assign pal_sel  = host_req_i.addr[`VID_HOST_AW-1:`VID_PAL_BYTES_AW] ==
                      PAL_BASE[`VID_HOST_AW-1:`VID_PAL_BYTES_AW];
    assign ctrl_sel = host_req_i.addr == CTRL_ADDR;
    assign stat_sel = host_req_i.addr == STAT_ADDR;

    assign host_ram = host_req_i.strobe && ram_sel;
    assign host_wr  = host_req_i.strobe && host_req_i.write;
    assign pal_we_o = host_wr && pal_sel;

    //////////////////////////////////////////////////
    // Memory bus arbitration
    //////////////////////////////////////////////////
    always_comb begin
        mem_req_o = fetch_req_i;
        // Host always wins the bus
        if (host_ram) begin
            mem_req_o.strobe  = 1'b1;
            mem_req_o.write   = host_req_i.write;
            mem_req_o.addr    = host_req_i.addr[`VID_RAM_AW+1:2];
            mem_req_o.bytesel = 4'b0001 << host_req_i.addr[1:0];
            mem_req_o.wrdata  = {4{host_req_i.wrdata}};
        end
    end

    //////////////////////////////////////////////////
    // Control, status and read steering
    //////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fetch_ack_o <= 1'b0;
            rdvalid_o   <= 1'b0;
            rd_ram_r    <= 1'b0;
            rd_pal_r    <= 1'b0;
            ctrl_r      <= '0;
            eos_flag_r  <= 1'b0;
        end else begin
            fetch_ack_o <= fetch_req_i.strobe && !host_ram;
            rdvalid_o   <= host_req_i.strobe && !host_req_i.write;
            rd_ram_r    <= ram_sel;
            rd_pal_r    <= pal_sel;
            if (host_wr && ctrl_sel) begin
                ctrl_r <= host_req_i.wrdata[1:0];
            end
            // New end of screen beats a clear in the same cycle
            if (evt_i.end_of_screen) begin
                eos_flag_r <= 1'b1;
            end else if (host_wr && stat_sel && host_req_i.wrdata[0]) begin
                eos_flag_r <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        lane_r       <= host_req_i.addr[1:0];
        reg_rddata_r <= ctrl_sel ? {6'b0, ctrl_r} :
                        stat_sel ? {7'b0, eos_flag_r} : 8'h00;
    end

    always_comb begin
        rddata_o = reg_rddata_r;
        if (rd_ram_r) begin
            rddata_o = mem_rddata_i[lane_r*8 +: 8];
        end else if (rd_pal_r) begin
            rddata_o = pal_rdbyte_i;
        end
    end

    assign display_en_o = ctrl_r[0];
    assign irq_o        = eos_flag_r && ctrl_r[1];

    // Host strobe is a single-cycle pulse
    a_host_pulse: assert property (@(posedge clk) disable iff (reset)
        host_req_i.strobe |=> !host_req_i.strobe);

endmodule

// ==== vid_pkg.sv ====
`include "vid_consts.svh"

package vid_pkg;

    typedef logic [`VID_HOST_AW-1:0] host_addr_t;
    typedef logic [7:0]              byte_t;
    typedef logic [31:0]             mem_word_t;
    typedef logic [`VID_RAM_AW-1:0]  ram_addr_t;
    typedef logic [`VID_PIX_W-1:0]   pix_idx_t;
    typedef logic [`VID_LINE_W-1:0]  line_idx_t;
    typedef logic [11:0]             rgb12_t;

    // Line fetch engine
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT,
        DONE
    } fetch_state_t;

    // Host register bus, strobe is a single-cycle pulse
    typedef struct packed {
        logic       strobe;
        logic       write;
        host_addr_t addr;
        byte_t      wrdata;
    } host_req_t;

    // Memory bus towards main RAM
    typedef struct packed {
        logic       strobe;
        logic       write;
        ram_addr_t  addr;
        logic [3:0] bytesel;
        mem_word_t  wrdata;
    } mem_req_t;

    // Events from the video timing generator
    typedef struct packed {
        logic      start_of_line;
        logic      start_of_screen;
        logic      end_of_screen;
        line_idx_t next_line;
        logic      active;
        pix_idx_t  pix_idx;
    } video_evt_t;

endpackage

// ==== vid_consts.svh ====
`ifndef VID_CONSTS_SVH
`define VID_CONSTS_SVH

// Host bus
`define VID_HOST_AW         16

// Main RAM, 32-bit words
`define VID_RAM_WORDS       1024
`define VID_RAM_AW          10

// Host memory map
`define VID_PAL_BASE        16'h8000
`define VID_PAL_BYTES_AW    9
`define VID_CTRL_ADDR       16'h8200
`define VID_STAT_ADDR       16'h8201

// Horizontal timing in pixel clocks
`define VID_H_ACTIVE        16
`define VID_H_SYNC_START    18
`define VID_H_SYNC_LEN      2
`define VID_H_TOTAL         24

// Vertical timing in lines
`define VID_V_ACTIVE        8
`define VID_V_SYNC_START    9
`define VID_V_SYNC_LEN      1
`define VID_V_TOTAL         11

// Four 8-bit pixels per word
`define VID_WORDS_PER_LINE  4

// Counter widths
`define VID_PIX_W           5
`define VID_LINE_W          4

`endif
